// File: logic/ram_ctrl_pkg.sv
// ram controller state and region rules
`default_nettype none

package ram_ctrl_pkg;

   ////////////////////////////////////////
   // requester state bit positions
   ////////////////////////////////////////

   typedef enum int unsigned {
      idle       = 0,
      read       = 1,
      read_busy  = 2,
      read_wait  = 3,
      write      = 4,
      write_busy = 5,
      write_wait = 6
   } sd_state_index;

   // one bit per state
   typedef logic [6:0] sd_state_t;

   // one-hot codes, each built from its bit position
   localparam sd_state_t state_idle       = sd_state_t'(1) << idle;
   localparam sd_state_t state_read       = sd_state_t'(1) << read;
   localparam sd_state_t state_read_busy  = sd_state_t'(1) << read_busy;
   localparam sd_state_t state_read_wait  = sd_state_t'(1) << read_wait;
   localparam sd_state_t state_write      = sd_state_t'(1) << write;
   localparam sd_state_t state_write_busy = sd_state_t'(1) << write_busy;
   localparam sd_state_t state_write_wait = sd_state_t'(1) << write_wait;

   ////////////////////////////////////////
   // region rule
   ////////////////////////////////////////

   localparam int region_width = 5;

   // returned for any read outside region zero
   localparam logic [31:0] out_of_range_word = 32'hffff_ffff;

   // only region zero is backed by memory
   function automatic logic region_in_range(input logic [region_width-1:0] region);
      return region == '0;
   endfunction

endpackage

`default_nettype wire

// File: logic/mem_app_pkg.sv
// memory application interface definitions
`default_nettype none

package mem_app_pkg;

   ////////////////////////////////////////
   // command encoding
   ////////////////////////////////////////

   typedef logic [2:0] app_cmd_t;

   localparam app_cmd_t cmd_write = 3'b000;
   localparam app_cmd_t cmd_read  = 3'b001;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   localparam int sdram_addr_width = 22;
   localparam int offset_width     = 17;
   localparam int data_width       = 32;

   // region sits above the offset
   localparam int addr_region_width = sdram_addr_width - offset_width;

   ////////////////////////////////////////
   // cpu word address, two views
   ////////////////////////////////////////

   // flat index as the cpu sees it, or region plus offset for decode
   typedef union packed {
      logic [sdram_addr_width-1:0] flat;
      struct packed {
         logic [addr_region_width-1:0] region;
         logic [offset_width-1:0]      offset;
      } fields;
   } sdram_addr_u;

endpackage

`default_nettype wire

// File: logic/sdram_sequencer.sv
// main memory request sequencer
`default_nettype none

module sdram_sequencer (
   input  wire                                  clk,
   input  wire                                  reset,
   // cpu side
   input  wire                                  sdram_req,
   input  wire                                  sdram_write,
   input  mem_app_pkg::sdram_addr_u             sdram_addr,
   output logic [mem_app_pkg::data_width-1:0]   sdram_data_out,
   output logic                                 sdram_ready,
   output logic                                 sdram_done,
   // memory side
   input  wire                                  app_rdy,
   output logic                                 app_en,
   output mem_app_pkg::app_cmd_t                app_cmd,
   output logic [mem_app_pkg::offset_width-1:0] app_addr,
   output logic                                 app_wdf_wren,
   input  wire  [mem_app_pkg::data_width-1:0]   app_rd_data,
   input  wire                                  app_rd_valid
);

   ram_ctrl_pkg::sd_state_t state;
   ram_ctrl_pkg::sd_state_t state_next;
   logic                    in_range;
   logic                    issue_write;

   // region decode from the field view
   assign in_range = ram_ctrl_pkg::region_in_range(sdram_addr.fields.region);

   ////////////////////////////////////////
   // state register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ram_ctrl_pkg::state_idle;
      end else begin
         state <= state_next;
      end
   end

   // read wins if the cpu ever raised both
   always_comb begin
      state_next = state;
      if (state[ram_ctrl_pkg::idle] && sdram_req) begin
         state_next = ram_ctrl_pkg::state_read;
      end else if (state[ram_ctrl_pkg::idle] && sdram_write) begin
         state_next = ram_ctrl_pkg::state_write;
      end else if (state[ram_ctrl_pkg::read] && app_rdy) begin
         state_next = ram_ctrl_pkg::state_read_busy;
      end else if (state[ram_ctrl_pkg::read_busy] && app_rd_valid) begin
         state_next = ram_ctrl_pkg::state_read_wait;
      end else if (state[ram_ctrl_pkg::read_wait] && !sdram_req) begin
         state_next = ram_ctrl_pkg::state_idle;
      end else if (state[ram_ctrl_pkg::write] && (app_rdy || !in_range)) begin
         // dropped writes skip the memory but still move on
         state_next = ram_ctrl_pkg::state_write_busy;
      end else if (state[ram_ctrl_pkg::write_busy]) begin
         state_next = ram_ctrl_pkg::state_write_wait;
      end else if (state[ram_ctrl_pkg::write_wait] && !sdram_write) begin
         state_next = ram_ctrl_pkg::state_idle;
      end
   end

   ////////////////////////////////////////
   // memory interface strobes
   ////////////////////////////////////////

   // write data travels with the write command
   assign issue_write  = state[ram_ctrl_pkg::write] && app_rdy && in_range;
   assign app_wdf_wren = issue_write;
   assign app_en       = (state[ram_ctrl_pkg::read] && app_rdy) || issue_write;
   assign app_cmd      = state[ram_ctrl_pkg::write] ? mem_app_pkg::cmd_write
                                                    : mem_app_pkg::cmd_read;
   // memory only sees the offset
   assign app_addr     = sdram_addr.fields.offset;

   // read result, replaced outside region zero
   always_ff @(posedge clk) begin
      if (reset) begin
         sdram_data_out <= '0;
      end else if (state[ram_ctrl_pkg::read_busy] && app_rd_valid) begin
         sdram_data_out <= in_range ? app_rd_data : ram_ctrl_pkg::out_of_range_word;
      end
   end

   // answers held in the wait states
   assign sdram_ready = state[ram_ctrl_pkg::read_wait];
   assign sdram_done  = state[ram_ctrl_pkg::write_wait];

   // exactly one state bit at any time
   a_state_onehot : assert property (@(posedge clk) disable iff (reset)
      $onehot(state));

   // read data only comes back while a read is in flight
   a_valid_when_busy : assert property (@(posedge clk) disable iff (reset)
      app_rd_valid |-> state[ram_ctrl_pkg::read_busy]);

endmodule

`default_nettype wire

// File: logic/access_delay_timer.sv
// access delay timer
`default_nettype none

module access_delay_timer #(
   parameter int delay = 4
) (
   input  wire  clk,
   input  wire  reset,
   input  wire  req,
   output logic ready
);

   // wide enough to hold delay itself
   localparam int count_bits = (delay < 1) ? 1 : $clog2(delay + 1);

   logic [count_bits-1:0] count;

   ////////////////////////////////////////
   // held-request counter
   ////////////////////////////////////////

   // counts cycles of a held request, sticks at delay
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (!req) begin
         // released request starts over
         count <= '0;
      end else if (count != count_bits'(delay)) begin
         count <= count + 1'b1;
      end
   end

   // ready once the full delay has passed
   assign ready = (count == count_bits'(delay));

   // ready only ever follows a request
   a_ready_after_req : assert property (@(posedge clk) disable iff (reset)
      ready |-> $past(req));

endmodule

`default_nettype wire

// File: logic/app_memory.sv
// behavioral application memory
`default_nettype none

module app_memory #(
   parameter int mem_addr_bits = 10,
   parameter int read_latency  = 3
) (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire                                  app_en,
   input  mem_app_pkg::app_cmd_t                app_cmd,
   input  wire  [mem_app_pkg::offset_width-1:0] app_addr,
   input  wire                                  app_wdf_wren,
   input  wire  [mem_app_pkg::data_width-1:0]   app_wdf_data,
   output logic                                 app_rdy,
   output logic [mem_app_pkg::data_width-1:0]   app_rd_data,
   output logic                                 app_rd_valid
);

   // countdown has to reach read_latency
   localparam int wait_bits = (read_latency < 1) ? 1 : $clog2(read_latency + 1);

   logic [mem_app_pkg::data_width-1:0] mem [2**mem_addr_bits];
   logic [mem_addr_bits-1:0]           word_index;
   logic [wait_bits-1:0]               wait_count;
   logic                               accept_read;
   logic                               accept_write;

   // low address bits pick the word
   assign word_index = app_addr[mem_addr_bits-1:0];

   ////////////////////////////////////////
   // command accept
   ////////////////////////////////////////

   // commands only taken while idle
   assign accept_read  = app_en && app_rdy && (app_cmd == mem_app_pkg::cmd_read);
   assign accept_write = app_en && app_rdy && (app_cmd == mem_app_pkg::cmd_write)
                         && app_wdf_wren;

   // write lands on the accept edge
   always_ff @(posedge clk) begin
      if (accept_write) begin
         mem[word_index] <= app_wdf_data;
      end
   end

   // word fetched at accept, shown later
   always_ff @(posedge clk) begin
      if (accept_read) begin
         app_rd_data <= mem[word_index];
      end
   end

   ////////////////////////////////////////
   // read latency countdown
   ////////////////////////////////////////

   // loaded on read accept, runs down to zero
   always_ff @(posedge clk) begin
      if (reset) begin
         wait_count <= '0;
      end else if (accept_read) begin
         wait_count <= wait_bits'(read_latency);
      end else if (wait_count != '0) begin
         wait_count <= wait_count - 1'b1;
      end
   end

   // busy window covers the whole countdown
   assign app_rdy = (wait_count == '0);

   // last count step is the data cycle
   assign app_rd_valid = (wait_count == wait_bits'(1));

   // requester must pair write data with the write command
   a_write_has_data : assert property (@(posedge clk) disable iff (reset)
      (app_en && app_cmd == mem_app_pkg::cmd_write) |-> app_wdf_wren);

endmodule

`default_nettype wire

// File: logic/video_ram.sv
// dual port video ram
`default_nettype none

module video_ram #(
   parameter int vram_addr_bits = 15
) (
   input  wire                      clk,
   input  wire                      reset,
   // cpu port
   input  wire                      cpu_en,
   input  wire                      cpu_write,
   input  wire [vram_addr_bits-1:0] cpu_addr,
   input  wire [31:0]               cpu_data_in,
   output logic [31:0]              cpu_data_out,
   // display port
   input  wire                      vga_en,
   input  wire                      vga_ready,
   input  wire [vram_addr_bits-1:0] vga_addr,
   output logic [31:0]              vga_data_out
);

   logic [31:0] mem [2**vram_addr_bits];
   logic [31:0] vga_ram_out;
   logic [31:0] vga_hold;

   ////////////////////////////////////////
   // cpu port
   ////////////////////////////////////////

   // write every enabled cycle, read returns the old word
   always_ff @(posedge clk) begin
      if (cpu_en) begin
         if (cpu_write) begin
            mem[cpu_addr] <= cpu_data_in;
         end
         cpu_data_out <= mem[cpu_addr];
      end
   end

   ////////////////////////////////////////
   // display port
   ////////////////////////////////////////

   // read only, registered one cycle after the address
   always_ff @(posedge clk) begin
      if (vga_en) begin
         vga_ram_out <= mem[vga_addr];
      end
   end

   // last good word, kept once the port goes quiet
   always_ff @(posedge clk) begin
      if (reset) begin
         vga_hold <= '0;
      end else if (vga_ready) begin
         vga_hold <= vga_ram_out;
      end
   end

   // live data while ready, else the held word
   assign vga_data_out = vga_ready ? vga_ram_out : vga_hold;

endmodule

`default_nettype wire

// File: logic/ram_controller.sv
// ram controller top level
`default_nettype none

module ram_controller #(
   parameter int mem_addr_bits  = 10,
   parameter int read_latency   = 3,
   parameter int vram_addr_bits = 15
) (
   input  wire                                clk,
   input  wire                                reset,
   // main memory port
   input  wire                                sdram_req,
   input  wire                                sdram_write,
   input  mem_app_pkg::sdram_addr_u           sdram_addr,
   input  wire  [mem_app_pkg::data_width-1:0] sdram_data_in,
   output logic [mem_app_pkg::data_width-1:0] sdram_data_out,
   output logic                               sdram_ready,
   output logic                               sdram_done,
   // video ram cpu port
   input  wire                                vram_cpu_req,
   input  wire                                vram_cpu_write,
   input  wire  [vram_addr_bits-1:0]          vram_cpu_addr,
   input  wire  [31:0]                        vram_cpu_data_in,
   output logic [31:0]                        vram_cpu_data_out,
   output logic                               vram_cpu_ready,
   output logic                               vram_cpu_done,
   // video ram display port
   input  wire                                vram_vga_req,
   input  wire  [vram_addr_bits-1:0]          vram_vga_addr,
   output logic [31:0]                        vram_vga_data_out,
   output logic                               vram_vga_ready
);

   // sequencer to memory
   logic                                 app_rdy;
   logic                                 app_en;
   mem_app_pkg::app_cmd_t                app_cmd;
   logic [mem_app_pkg::offset_width-1:0] app_addr;
   logic                                 app_wdf_wren;
   logic [mem_app_pkg::data_width-1:0]   app_rd_data;
   logic                                 app_rd_valid;

   // video ram cpu side
   logic                                 vram_cpu_en;
   logic                                 cpu_timer_ready;

   ////////////////////////////////////////
   // main memory path
   ////////////////////////////////////////

   sdram_sequencer u_sequencer (
      .clk            (clk),
      .reset          (reset),
      .sdram_req      (sdram_req),
      .sdram_write    (sdram_write),
      .sdram_addr     (sdram_addr),
      .sdram_data_out (sdram_data_out),
      .sdram_ready    (sdram_ready),
      .sdram_done     (sdram_done),
      .app_rdy        (app_rdy),
      .app_en         (app_en),
      .app_cmd        (app_cmd),
      .app_addr       (app_addr),
      .app_wdf_wren   (app_wdf_wren),
      .app_rd_data    (app_rd_data),
      .app_rd_valid   (app_rd_valid)
   );

   // write data goes straight from the cpu
   app_memory #(
      .mem_addr_bits (mem_addr_bits),
      .read_latency  (read_latency)
   ) u_app_memory (
      .clk          (clk),
      .reset        (reset),
      .app_en       (app_en),
      .app_cmd      (app_cmd),
      .app_addr     (app_addr),
      .app_wdf_wren (app_wdf_wren),
      .app_wdf_data (sdram_data_in),
      .app_rdy      (app_rdy),
      .app_rd_data  (app_rd_data),
      .app_rd_valid (app_rd_valid)
   );

   ////////////////////////////////////////
   // video ram path
   ////////////////////////////////////////

   // either cpu request opens the port
   assign vram_cpu_en = vram_cpu_req | vram_cpu_write;

   // one timer serves both cpu reads and writes
   access_delay_timer #(.delay(4)) u_cpu_timer (
      .clk   (clk),
      .reset (reset),
      .req   (vram_cpu_en),
      .ready (cpu_timer_ready)
   );

   assign vram_cpu_ready = cpu_timer_ready & vram_cpu_req;
   assign vram_cpu_done  = cpu_timer_ready & vram_cpu_write;

   // display data is back one cycle after the address
   access_delay_timer #(.delay(1)) u_vga_timer (
      .clk   (clk),
      .reset (reset),
      .req   (vram_vga_req),
      .ready (vram_vga_ready)
   );

   video_ram #(
      .vram_addr_bits (vram_addr_bits)
   ) u_video_ram (
      .clk          (clk),
      .reset        (reset),
      .cpu_en       (vram_cpu_en),
      .cpu_write    (vram_cpu_write),
      .cpu_addr     (vram_cpu_addr),
      .cpu_data_in  (vram_cpu_data_in),
      .cpu_data_out (vram_cpu_data_out),
      .vga_en       (vram_vga_req),
      .vga_ready    (vram_vga_ready),
      .vga_addr     (vram_vga_addr),
      .vga_data_out (vram_vga_data_out)
   );

endmodule

`default_nettype wire

// File: sim/ram_ctrl_vectors.svh
// ram controller test vectors
`ifndef ram_ctrl_vectors_svh
`define ram_ctrl_vectors_svh

// operation kinds
localparam logic [2:0] op_main_write = 3'd0;
localparam logic [2:0] op_main_read  = 3'd1;
localparam logic [2:0] op_vram_write = 3'd2;
localparam logic [2:0] op_vram_read  = 3'd3;
localparam logic [2:0] op_vga_read   = 3'd4;

// entry layout
//   kind         one of the operation kinds above
//   addr         main memory flat address, video address in the low bits
//   from_shadow  expected word is the last one written to addr
//   expect_word  fixed expected word when from_shadow is low
typedef struct packed {
   logic [2:0]  kind;
   logic [21:0] addr;
   logic        from_shadow;
   logic [31:0] expect_word;
} vector_t;

localparam int num_vectors = 13;

// region sits in addr bits 21:17
localparam vector_t vectors [num_vectors] = '{
   '{op_main_write, 22'h000010, 1'b0, 32'h0000_0000},
   '{op_main_write, 22'h000123, 1'b0, 32'h0000_0000},
   '{op_main_read,  22'h000010, 1'b1, 32'h0000_0000},
   '{op_main_read,  22'h000123, 1'b1, 32'h0000_0000},
   // region 2, nothing behind it
   '{op_main_read,  22'h040010, 1'b0, 32'hffff_ffff},
   // region 1 write, same offset as the first entry
   '{op_main_write, 22'h020010, 1'b0, 32'h0000_0000},
   '{op_main_read,  22'h000010, 1'b1, 32'h0000_0000},
   '{op_main_read,  22'h020010, 1'b0, 32'hffff_ffff},
   '{op_vram_write, 22'h000005, 1'b0, 32'h0000_0000},
   '{op_vram_read,  22'h000005, 1'b1, 32'h0000_0000},
   '{op_vga_read,   22'h000005, 1'b1, 32'h0000_0000},
   '{op_vram_write, 22'h00003a, 1'b0, 32'h0000_0000},
   '{op_vga_read,   22'h00003a, 1'b1, 32'h0000_0000}
};

`endif

// File: sim/tb_ram_controller.sv
// ram controller testbench
`default_nettype none

module tb_ram_controller;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int read_latency   = 3;
   localparam int vram_addr_bits = 8;
   // access delays of the two video ports
   localparam int cpu_delay = 4;
   localparam int vga_delay = 1;

   `include "ram_ctrl_vectors.svh"

   localparam int cycle_limit = num_vectors * (read_latency + 12);

   logic                      clk;
   logic                      reset;
   logic                      sdram_req;
   logic                      sdram_write;
   mem_app_pkg::sdram_addr_u  sdram_addr;
   logic [31:0]               sdram_data_in;
   logic [31:0]               sdram_data_out;
   logic                      sdram_ready;
   logic                      sdram_done;
   logic                      vram_cpu_req;
   logic                      vram_cpu_write;
   logic [vram_addr_bits-1:0] vram_cpu_addr;
   logic [31:0]               vram_cpu_data_in;
   logic [31:0]               vram_cpu_data_out;
   logic                      vram_cpu_ready;
   logic                      vram_cpu_done;
   logic                      vram_vga_req;
   logic [vram_addr_bits-1:0] vram_vga_addr;
   logic [31:0]               vram_vga_data_out;
   logic                      vram_vga_ready;

   // words written so far, keyed by address
   logic [31:0] main_shadow [logic [21:0]];
   logic [31:0] vram_shadow [logic [vram_addr_bits-1:0]];

   int   cycle_count = 0;
   int   error_count;
   int   failed_tests;
   logic test_failed;

   ram_controller #(
      .read_latency   (read_latency),
      .vram_addr_bits (vram_addr_bits)
   ) u_dut (
      .clk               (clk),
      .reset             (reset),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_data_out    (sdram_data_out),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_cpu_done     (vram_cpu_done),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready)
   );

   ////////////////////////////////////////
   // clock and run limit
   ////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, a handshake never completed", cycle_count);
         $display("Errors found");
         $finish;
      end
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   function automatic void note_failure();
      error_count++;
      test_failed = 1'b1;
   endfunction

   function automatic string kind_name(input logic [2:0] kind);
      case (kind)
         op_main_write: return "main write";
         op_main_read:  return "main read";
         op_vram_write: return "vram cpu write";
         op_vram_read:  return "vram cpu read";
         default:       return "display read";
      endcase
   endfunction

   // lower every request, then sit one cycle past the drop
   task automatic release_requests();
      @(posedge clk);
      sdram_req      <= 1'b0;
      sdram_write    <= 1'b0;
      vram_cpu_req   <= 1'b0;
      vram_cpu_write <= 1'b0;
      vram_vga_req   <= 1'b0;
      @(posedge clk);
      @(negedge clk);
   endtask

   // one main memory access, write or read
   task automatic main_access(input logic is_write, input vector_t v);
      mem_app_pkg::sdram_addr_u addr_view;
      logic [31:0]              word;
      logic [31:0]              expected;
      addr_view.flat = v.addr;
      word = $urandom;
      expected = v.from_shadow ? main_shadow[v.addr] : v.expect_word;
      @(posedge clk);
      sdram_addr    <= addr_view;
      sdram_data_in <= word;
      sdram_write   <= is_write;
      sdram_req     <= !is_write;
      @(negedge clk);
      while (!(is_write ? sdram_done : sdram_ready)) begin
         @(negedge clk);
      end
      // only region zero keeps what is written
      if (is_write && addr_view.fields.region == '0) begin
         main_shadow[v.addr] = word;
      end
      if (!is_write && sdram_data_out != expected) begin
         $display("[ERROR] sdram_data_out got %h expected %h", sdram_data_out, expected);
         note_failure();
      end
      release_requests();
      if (sdram_ready || sdram_done) begin
         $display("main memory answer still high a cycle after the request dropped");
         note_failure();
      end
   endtask

   // video ram cpu port, ready or done counted in edges from the drive
   task automatic vram_cpu_access(input logic is_write, input vector_t v);
      logic [vram_addr_bits-1:0] addr;
      logic [31:0]               word;
      int                        waited;
      addr = v.addr[vram_addr_bits-1:0];
      word = $urandom;
      waited = 0;
      @(posedge clk);
      vram_cpu_addr    <= addr;
      vram_cpu_data_in <= word;
      vram_cpu_write   <= is_write;
      vram_cpu_req     <= !is_write;
      @(negedge clk);
      while (!(is_write ? vram_cpu_done : vram_cpu_ready)) begin
         @(negedge clk);
         waited++;
      end
      if (waited != cpu_delay) begin
         $display("[ERROR] %s delay got %h expected %h",
                  is_write ? "vram_cpu_done" : "vram_cpu_ready", waited, cpu_delay);
         note_failure();
      end
      if (is_write) begin
         vram_shadow[addr] = word;
      end else if (vram_cpu_data_out != vram_shadow[addr]) begin
         $display("[ERROR] vram_cpu_data_out got %h expected %h",
                  vram_cpu_data_out, vram_shadow[addr]);
         note_failure();
      end
      release_requests();
      if (vram_cpu_ready || vram_cpu_done) begin
         $display("vram cpu answer still high a cycle after the request dropped");
         note_failure();
      end
   endtask

   // display read, the word must outlast the request
   task automatic display_read(input vector_t v);
      logic [vram_addr_bits-1:0] addr;
      int                        waited;
      addr = v.addr[vram_addr_bits-1:0];
      waited = 0;
      @(posedge clk);
      vram_vga_addr <= addr;
      vram_vga_req  <= 1'b1;
      @(negedge clk);
      while (!vram_vga_ready) begin
         @(negedge clk);
         waited++;
      end
      if (waited != vga_delay) begin
         $display("[ERROR] vram_vga_ready delay got %h expected %h", waited, vga_delay);
         note_failure();
      end
      if (vram_vga_data_out != vram_shadow[addr]) begin
         $display("[ERROR] vram_vga_data_out got %h expected %h",
                  vram_vga_data_out, vram_shadow[addr]);
         note_failure();
      end
      release_requests();
      if (vram_vga_ready) begin
         $display("vram_vga_ready still high a cycle after the request dropped");
         note_failure();
      end
      if (vram_vga_data_out != vram_shadow[addr]) begin
         $display("[ERROR] held vram_vga_data_out got %h expected %h",
                  vram_vga_data_out, vram_shadow[addr]);
         note_failure();
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      void'($urandom(32'ha868));
      reset            = 1'b1;
      sdram_req        = 1'b0;
      sdram_write      = 1'b0;
      sdram_addr       = '0;
      sdram_data_in    = '0;
      vram_cpu_req     = 1'b0;
      vram_cpu_write   = 1'b0;
      vram_cpu_addr    = '0;
      vram_cpu_data_in = '0;
      vram_vga_req     = 1'b0;
      vram_vga_addr    = '0;
      error_count      = 0;
      failed_tests     = 0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);

      // quiet outputs straight out of reset
      test_failed = 1'b0;
      if (sdram_ready || sdram_done || vram_cpu_ready || vram_vga_ready) begin
         $display("a handshake output is high right after reset");
         note_failure();
      end
      if (sdram_data_out != 32'h0) begin
         $display("[ERROR] sdram_data_out got %h expected %h", sdram_data_out, 32'h0);
         note_failure();
      end
      if (test_failed) begin
         failed_tests++;
      end
      $display("test 0 reset state: %s", test_failed ? "fail" : "pass");

      for (int i = 0; i < num_vectors; i++) begin
         test_failed = 1'b0;
         case (vectors[i].kind)
            op_main_write: main_access(1'b1, vectors[i]);
            op_main_read:  main_access(1'b0, vectors[i]);
            op_vram_write: vram_cpu_access(1'b1, vectors[i]);
            op_vram_read:  vram_cpu_access(1'b0, vectors[i]);
            default:       display_read(vectors[i]);
         endcase
         if (test_failed) begin
            failed_tests++;
         end
         $display("test %0d %s at %h: %s", i + 1, kind_name(vectors[i].kind),
                  vectors[i].addr, test_failed ? "fail" : "pass");
      end

      $display("%0d tests, %0d failed, %0d failed checks",
               num_vectors + 1, failed_tests, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
logic/ram_ctrl_pkg.sv
logic/mem_app_pkg.sv
logic/sdram_sequencer.sv
logic/access_delay_timer.sv
logic/app_memory.sv
logic/video_ram.sv
logic/ram_controller.sv
+incdir+sim
sim/tb_ram_controller.sv

// File: Makefile
# simulator and build settings
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ram_controller
FILELIST  = src.f
PASS_MSG  = No errors

.PHONY: simulate clean

# build, run, then look for the pass line in the output
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
